//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_rv_pipe
FILELIST  = tb.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

//--- alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module alu_execute import rv_pkg::*; (
    input  wire ir_type_t   ir_type,
    input  wire alu_op_t    alu_op,
    input  wire word_t      op_a,
    input  wire word_t      op_b,
    input  wire word_t      rs1_val,
    input  wire reg_idx_t   rd,
    input  wire             wr_reg_n,
    input  wire word_t      csr_rdata,
    output word_t           c,
    output word_t           d,
    output word_t           z,
    output logic            fwd_en,
    output reg_idx_t        fwd_rd,
    output word_t           fwd_data
);

    logic [4:0] shamt;

    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ADD:     c = op_a + op_b;
            SUB:     c = op_a - op_b;
            AND:     c = op_a & op_b;
            OR:      c = op_a | op_b;
            XOR:     c = op_a ^ op_b;
            SLL:     c = op_a << shamt;
            SRL:     c = op_a >> shamt;
            SRA:     c = $signed(op_a) >>> shamt;
            SLT:     c = {31'b0, $signed(op_a) < $signed(op_b)};
            SLTU:    c = {31'b0, op_a < op_b};
            PASS_B:  c = op_b;
            default: c = op_a + op_b;
        endcase
    end

    // CSR read-modify.
    assign d = csr_rdata;

    always_comb begin
        case (ir_type)
            IR_CSRRW: z = rs1_val;
            IR_CSRRS: z = csr_rdata | rs1_val;
            default:  z = csr_rdata; // No change.
        endcase
    end

    // ************************************************************************
    // Forwarding to decode.
    // ************************************************************************
    assign fwd_en = !wr_reg_n && rd != '0;
    assign fwd_rd = rd;

    // Links already arrive as pc + 4 in c.
    always_comb begin
        case (ir_type)
            IR_CSRRW, IR_CSRRS: fwd_data = d;
            default:            fwd_data = c;
        endcase
    end

endmodule

`default_nettype wire

//--- csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file import rv_pkg::*; #(
    parameter int CSR_COUNT = 4
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire csr_addr_t  raddr,
    input  wire             we,
    input  wire csr_addr_t  waddr,
    input  wire word_t      wdata,
    output word_t           rdata
);

    word_t csr_q [CSR_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < CSR_COUNT; i++)
                csr_q[i] <= '0;
        end else if (we) begin
            for (int i = 0; i < CSR_COUNT; i++) begin
                if (waddr == csr_addr_t'(CSR_BASE + i))
                    csr_q[i] <= wdata;
            end
        end
    end

    // Outside the bank reads zero.
    always_comb begin
        rdata = '0;
        for (int i = 0; i < CSR_COUNT; i++) begin
            if (raddr == csr_addr_t'(CSR_BASE + i))
                rdata = (we && waddr == raddr) ? wdata : csr_q[i]; // Bypass.
        end
    end

endmodule

`default_nettype wire

//--- instr_decode.sv
`timescale 1ns/1ps
`include "pipeline_defaults.svh"
`default_nettype none

module instr_decode import rv_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             interlock,
    input  wire             instr_valid,
    input  wire word_t      instr,
    input  wire word_t      pc,
    input  wire word_t      rs1_rdata,
    input  wire word_t      rs2_rdata,
    input  wire             fwd_en,
    input  wire reg_idx_t   fwd_rd,
    input  wire word_t      fwd_data,
    output reg_idx_t        rs1_addr,
    output reg_idx_t        rs2_addr,
    output ir_type_t        ir_type,
    output alu_op_t         alu_op,
    output word_t           op_a,
    output word_t           op_b,
    output word_t           rs1_val,
    output word_t           pc4,
    output reg_idx_t        rd,
    output csr_addr_t       csr_addr,
    output logic            wr_reg_n,
    output logic            wr_csr_n
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_u;
    word_t      rs1_fwd;
    word_t      rs2_fwd;
    ir_type_t   dec_type;
    alu_op_t    dec_op;
    word_t      dec_a;
    word_t      dec_b;

    function automatic alu_op_t alu_from_funct(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? SUB : ADD;
            F3_SLL:     return SLL;
            F3_SLT:     return SLT;
            F3_SLTU:    return SLTU;
            F3_XOR:     return XOR;
            F3_SRL_SRA: return alt ? SRA : SRL;
            F3_OR:      return OR;
            default:    return AND;
        endcase
    endfunction

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign imm_i    = {{20{instr[31]}}, instr[31:20]};
    assign imm_u    = {instr[31:12], 12'b0};

    // Execute result wins over the register file.
    assign rs1_fwd = (fwd_en && fwd_rd == rs1_addr) ? fwd_data : rs1_rdata;
    assign rs2_fwd = (fwd_en && fwd_rd == rs2_addr) ? fwd_data : rs2_rdata;

    // ************************************************************************
    // Class and ALU operation.
    // ************************************************************************
    always_comb begin
        dec_type = IR_NONE;
        dec_op   = ADD;
        case (opcode)
            OPC_OP: begin
                dec_type = IR_ALU_R;
                dec_op   = alu_from_funct(funct3, instr[30]);
            end
            OPC_OP_IMM: begin
                dec_type = IR_ALU_I;
                dec_op   = alu_from_funct(funct3, funct3 == F3_SRL_SRA && instr[30]);
            end
            OPC_LUI: begin
                dec_type = IR_LUI;
                dec_op   = PASS_B;
            end
            OPC_AUIPC: dec_type = IR_AUIPC;
            OPC_JAL:   dec_type = IR_JAL;
            OPC_JALR:  dec_type = IR_JALR;
            OPC_SYSTEM: begin
                if (funct3 == F3_CSRRW)
                    dec_type = IR_CSRRW;
                else if (funct3 == F3_CSRRS)
                    dec_type = IR_CSRRS;
            end
            default: dec_type = IR_NONE;
        endcase
        if (!instr_valid)
            dec_type = IR_NONE; // Bubble.
    end

    always_comb begin
        dec_a = rs1_fwd;
        dec_b = rs2_fwd;
        case (dec_type)
            IR_ALU_I: dec_b = imm_i;
            IR_LUI:   dec_b = imm_u;
            IR_AUIPC: begin
                dec_a = pc;
                dec_b = imm_u;
            end
            // Links go through the ALU as pc + 4 for forwarding.
            IR_JAL, IR_JALR: begin
                dec_a = pc;
                dec_b = 32'd4;
            end
            default: ;
        endcase
    end

    // ************************************************************************
    // Decode to execute register.
    // ************************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir_type  <= `DEFAULT_IR_TYPE;
            alu_op   <= `DEFAULT_ALU_OP;
            op_a     <= `DEFAULT_WORD;
            op_b     <= `DEFAULT_WORD;
            rs1_val  <= `DEFAULT_WORD;
            pc4      <= `DEFAULT_WORD;
            rd       <= `DEFAULT_REG_IDX;
            csr_addr <= `DEFAULT_CSR_ADDR;
            wr_reg_n <= `DEFAULT_WR_N;
            wr_csr_n <= `DEFAULT_WR_N;
        end else if (!interlock) begin
            ir_type  <= dec_type;
            alu_op   <= dec_op;
            op_a     <= dec_a;
            op_b     <= dec_b;
            rs1_val  <= rs1_fwd;
            pc4      <= pc + 32'd4;
            rd       <= instr[11:7];
            csr_addr <= instr[31:20];
            wr_reg_n <= (dec_type == IR_NONE);
            wr_csr_n <= !(dec_type == IR_CSRRW || dec_type == IR_CSRRS);
        end
    end

endmodule

`default_nettype wire

//--- pipeline_defaults.svh
`ifndef PIPELINE_DEFAULTS_SVH
`define PIPELINE_DEFAULTS_SVH

`default_nettype none

// Stage register reset values.
`define DEFAULT_WORD     '0
`define DEFAULT_REG_IDX  '0
`define DEFAULT_CSR_ADDR '0
`define DEFAULT_IR_TYPE  IR_NONE
`define DEFAULT_ALU_OP   ADD

// Write enables are active low.
`define DEFAULT_WR_N     1'b1

`default_nettype wire

`endif

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire reg_idx_t   rs1_addr,
    input  wire reg_idx_t   rs2_addr,
    input  wire             we,
    input  wire reg_idx_t   waddr,
    input  wire word_t      wdata,
    output word_t           rs1_rdata,
    output word_t           rs2_rdata
);

    word_t regs [1:31]; // x0 has no storage.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through so the instruction two behind sees the result.
    assign rs1_rdata = (rs1_addr == '0)                ? '0    :
                       (we && waddr == rs1_addr)       ? wdata :
                                                         regs[rs1_addr];
    assign rs2_rdata = (rs2_addr == '0)                ? '0    :
                       (we && waddr == rs2_addr)       ? wdata :
                                                         regs[rs2_addr];

endmodule

`default_nettype wire

//--- result_writeback.sv
`timescale 1ns/1ps
`include "pipeline_defaults.svh"
`default_nettype none

module result_writeback import rv_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             interlock,
    input  wire word_t      pc4_in,
    input  wire word_t      c_in,
    input  wire word_t      d_in,
    input  wire word_t      z_in,
    input  wire reg_idx_t   rd_in,
    input  wire csr_addr_t  csr_addr_in,
    input  wire ir_type_t   ir_type_in,
    input  wire             wr_reg_n_in,
    input  wire             wr_csr_n_in,
    output logic            rf_we,
    output reg_idx_t        rf_waddr,
    output word_t           rf_wdata,
    output logic            csr_we,
    output csr_addr_t       csr_waddr,
    output word_t           csr_wdata
);

    word_t     pc4_q;
    word_t     c_q;
    word_t     d_q;
    word_t     z_q;
    reg_idx_t  rd_q;
    csr_addr_t csr_addr_q;
    ir_type_t  ir_type_q;
    logic      wr_reg_n_q;
    logic      wr_csr_n_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc4_q      <= `DEFAULT_WORD;
            c_q        <= `DEFAULT_WORD;
            d_q        <= `DEFAULT_WORD;
            z_q        <= `DEFAULT_WORD;
            rd_q       <= `DEFAULT_REG_IDX;
            csr_addr_q <= `DEFAULT_CSR_ADDR;
            ir_type_q  <= `DEFAULT_IR_TYPE;
            wr_reg_n_q <= `DEFAULT_WR_N;
            wr_csr_n_q <= `DEFAULT_WR_N;
        end else if (!interlock) begin // Frozen otherwise.
            pc4_q      <= pc4_in;
            c_q        <= c_in;
            d_q        <= d_in;
            z_q        <= z_in;
            rd_q       <= rd_in;
            csr_addr_q <= csr_addr_in;
            ir_type_q  <= ir_type_in;
            wr_reg_n_q <= wr_reg_n_in;
            wr_csr_n_q <= wr_csr_n_in;
        end
    end

    // Writes wait for the first edge without interlock.
    assign rf_we    = !wr_reg_n_q && rd_q != '0 && !interlock;
    assign rf_waddr = rd_q;

    always_comb begin
        case (ir_type_q)
            IR_JAL, IR_JALR:    rf_wdata = pc4_q;
            IR_CSRRW, IR_CSRRS: rf_wdata = d_q; // Old CSR value.
            default:            rf_wdata = c_q;
        endcase
    end

    assign csr_we    = !wr_csr_n_q && !interlock;
    assign csr_waddr = csr_addr_q;
    assign csr_wdata = z_q;

endmodule

`default_nettype wire

//--- rv_pipe_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_chk import rv_pkg::*; (
    input wire            clk,
    input wire            rst_n,
    input wire            interlock,
    input wire            rf_we,
    input wire reg_idx_t  rf_waddr,
    input wire            csr_we
);

    // x0 is never a retire target.
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        rf_we |-> rf_waddr != '0)
        else $error("register write to x0");

    a_frozen_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        interlock |-> !rf_we && !csr_we)
        else $error("write enable high under interlock");

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !rf_we && !csr_we)
        else $error("write enable high in reset");

endmodule

bind rv_pipe_top rv_pipe_chk chk_i (
    .clk(clk), .rst_n(rst_n), .interlock(interlock),
    .rf_we(rf_we), .rf_waddr(rf_waddr), .csr_we(csr_we)
);

`default_nettype wire

//--- rv_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_top import rv_pkg::*; #(
    parameter int CSR_COUNT = 4
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             interlock,
    input  wire             instr_valid,
    input  wire word_t      instr,
    input  wire word_t      pc,
    output wire             rf_we,
    output wire reg_idx_t   rf_waddr,
    output wire word_t      rf_wdata,
    output wire             csr_we,
    output wire csr_addr_t  csr_waddr,
    output wire word_t      csr_wdata
);

    wire reg_idx_t  rs1_addr;
    wire reg_idx_t  rs2_addr;
    wire word_t     rs1_rdata;
    wire word_t     rs2_rdata;
    wire            fwd_en;
    wire reg_idx_t  fwd_rd;
    wire word_t     fwd_data;

    // Decode to execute.
    wire ir_type_t  ir_type;
    wire alu_op_t   alu_op;
    wire word_t     op_a;
    wire word_t     op_b;
    wire word_t     rs1_val;
    wire word_t     pc4;
    wire reg_idx_t  rd;
    wire csr_addr_t csr_addr;
    wire            wr_reg_n;
    wire            wr_csr_n;

    // Execute to result.
    wire word_t     csr_rdata;
    wire word_t     c;
    wire word_t     d;
    wire word_t     z;

    // ************************************************************************
    // Stages.
    // ************************************************************************
    instr_decode u_decode (
        .clk(clk), .rst_n(rst_n), .interlock(interlock),
        .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .rs1_rdata(rs1_rdata), .rs2_rdata(rs2_rdata),
        .fwd_en(fwd_en), .fwd_rd(fwd_rd), .fwd_data(fwd_data),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .ir_type(ir_type), .alu_op(alu_op), .op_a(op_a), .op_b(op_b),
        .rs1_val(rs1_val), .pc4(pc4), .rd(rd), .csr_addr(csr_addr),
        .wr_reg_n(wr_reg_n), .wr_csr_n(wr_csr_n)
    );

    alu_execute u_execute (
        .ir_type(ir_type), .alu_op(alu_op), .op_a(op_a), .op_b(op_b),
        .rs1_val(rs1_val), .rd(rd), .wr_reg_n(wr_reg_n), .csr_rdata(csr_rdata),
        .c(c), .d(d), .z(z),
        .fwd_en(fwd_en), .fwd_rd(fwd_rd), .fwd_data(fwd_data)
    );

    result_writeback u_result (
        .clk(clk), .rst_n(rst_n), .interlock(interlock),
        .pc4_in(pc4), .c_in(c), .d_in(d), .z_in(z), .rd_in(rd),
        .csr_addr_in(csr_addr), .ir_type_in(ir_type),
        .wr_reg_n_in(wr_reg_n), .wr_csr_n_in(wr_csr_n),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .csr_we(csr_we), .csr_waddr(csr_waddr), .csr_wdata(csr_wdata)
    );

    // ************************************************************************
    // Storage.
    // ************************************************************************
    reg_file u_regs (
        .clk(clk), .rst_n(rst_n),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .rs1_rdata(rs1_rdata), .rs2_rdata(rs2_rdata)
    );

    csr_file #(.CSR_COUNT(CSR_COUNT)) u_csrs (
        .clk(clk), .rst_n(rst_n),
        .raddr(csr_addr), // Read in execute, straight from decode.
        .we(csr_we), .waddr(csr_waddr), .wdata(csr_wdata),
        .rdata(csr_rdata)
    );

endmodule

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] csr_addr_t;

    // Instruction class, carried down the pipe.
    typedef enum logic [3:0] {
        IR_NONE,
        IR_ALU_R,
        IR_ALU_I,
        IR_LUI,
        IR_AUIPC,
        IR_JAL,
        IR_JALR,
        IR_CSRRW,
        IR_CSRRS
    } ir_type_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        PASS_B
    } alu_op_t;

    // Major opcodes.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_CSRRW   = 3'b001; // SYSTEM opcode.
    localparam logic [2:0] F3_CSRRS   = 3'b010;

    localparam csr_addr_t CSR_BASE = 12'h340; // First scratch CSR.

endpackage

`default_nettype wire

//--- tb.f
+incdir+.
rv_pkg.sv
instr_decode.sv
alu_execute.sv
result_writeback.sv
reg_file.sv
csr_file.sv
rv_pipe_top.sv
rv_pipe_chk.sv
tb_rv_pipe.sv

//--- tb_rv_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_pipe import rv_pkg::*; ();

    localparam int CSR_COUNT    = 4;
    localparam int RESET_CYCLES = 16;
    localparam int ISSUE_COUNT  = 260; // Instructions, bubbles and drain slots, rounded up.
    localparam int WATCHDOG_NS  = (RESET_CYCLES + 20 * ISSUE_COUNT) * 10;

    logic       clk;
    logic       rst_n;
    logic       interlock;
    logic       instr_valid;
    word_t      instr;
    word_t      pc;
    wire        rf_we;
    reg_idx_t   rf_waddr;
    word_t      rf_wdata;
    wire        csr_we;
    csr_addr_t  csr_waddr;
    word_t      csr_wdata;

    // Reference model and expected writes.
    word_t      regs [32];
    word_t      csrs [CSR_COUNT];
    int         rf_addr_q [$];
    word_t      rf_data_q [$];
    int         csr_addr_q [$];
    word_t      csr_data_q [$];
    logic [31:0] lfsr_q;
    word_t      pc_q;
    string      test_name;
    int         test_err;
    int         err_total;
    int         tests_run;
    bit         stall_mode;
    int         stall_left;
    bit         gap_check;
    int         cyc;
    int         last_rf;
    int         r_ops [10] = '{0, 8, 1, 2, 3, 4, 5, 13, 6, 7}; // {alt, funct3}.
    int         i_ops [9]  = '{0, 2, 3, 4, 6, 7, 1, 5, 13};

    rv_pipe_top #(.CSR_COUNT(CSR_COUNT)) dut_i (
        .clk(clk), .rst_n(rst_n), .interlock(interlock),
        .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .csr_we(csr_we), .csr_waddr(csr_waddr), .csr_wdata(csr_wdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // ************************************************************************
    // Helpers: random bits, encoders, reference ALU.
    // ************************************************************************
    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic word_t enc_r(input logic alt, input int rs2, input int rs1,
                                    input logic [2:0] f3, input int rd);
        return {1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input int rs1,
                                    input logic [2:0] f3, input int rd, input logic [6:0] opc);
        return {imm, 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input int rd,
                                    input logic [6:0] opc);
        return {imm, 5'(rd), opc};
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t ref_alu(input int op, input word_t a, input word_t b);
        case (op)
            0:       return a + b;
            8:       return a - b;
            1:       return a << b[4:0];
            2:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3:       return (a < b) ? 32'd1 : 32'd0;
            4:       return a ^ b;
            5:       return a >> b[4:0];
            13:      return $unsigned($signed(a) >>> b[4:0]);
            6:       return a | b;
            default: return a & b;
        endcase
    endfunction

    // ************************************************************************
    // Drive side.
    // ************************************************************************
    task automatic next_interlock();
        if (!stall_mode) begin
            interlock = 1'b0;
        end else if (stall_left > 0) begin
            interlock = 1'b1;
            stall_left--;
        end else if (rand_bits(2) == 0) begin
            interlock  = 1'b1;
            stall_left = int'(rand_bits(2));
        end else begin
            interlock = 1'b0;
        end
    endtask

    // Called 1 ns after an edge; returns 1 ns after the edge that takes it.
    task automatic send(input word_t ins, input int rd, input word_t rd_val,
                        input bit csr_wr, input csr_addr_t ca, input word_t cv);
        bit taken;
        instr_valid = 1'b1;
        instr       = ins;
        pc          = pc_q;
        pc_q        = pc_q + 4;
        if (rd != 0) begin
            regs[rd] = rd_val;
            rf_addr_q.push_back(rd);
            rf_data_q.push_back(rd_val);
        end
        if (csr_wr) begin
            csr_addr_q.push_back(int'(ca));
            csr_data_q.push_back(cv);
            if (ca >= CSR_BASE && int'(ca - CSR_BASE) < CSR_COUNT)
                csrs[int'(ca - CSR_BASE)] = cv;
        end
        do begin
            @(posedge clk);
            taken = !interlock;
            #1;
            next_interlock();
        end while (!taken);
        instr_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        instr_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
            next_interlock();
        end
    endtask

    task automatic alu_r(input int op, input int rd, input int rs1, input int rs2);
        send(enc_r(op[3], rs2, rs1, op[2:0], rd), rd, ref_alu(op, regs[rs1], regs[rs2]),
             0, '0, '0);
    endtask

    task automatic alu_i(input int op, input int rd, input int rs1, input logic [11:0] imm);
        logic [11:0] v;
        v = imm;
        if (op[2:0] == 3'd1 || op[2:0] == 3'd5)
            v = {1'b0, op[3], 5'b0, imm[4:0]}; // Shift amount form.
        send(enc_i(v, rs1, op[2:0], rd, OPC_OP_IMM), rd, ref_alu(op, regs[rs1], sext12(v)),
             0, '0, '0);
    endtask

    task automatic load_reg(input int rd, input word_t v);
        logic [19:0] hi;
        hi = v[31:12] + 20'(v[11]);
        send(enc_u(hi, rd, OPC_LUI), rd, {hi, 12'b0}, 0, '0, '0);
        alu_i(0, rd, rd, v[11:0]);
    endtask

    task automatic csr_op(input bit set, input int rd, input int rs1, input csr_addr_t ca);
        word_t old;
        old = '0;
        if (ca >= CSR_BASE && int'(ca - CSR_BASE) < CSR_COUNT)
            old = csrs[int'(ca - CSR_BASE)];
        send(enc_i(ca, rs1, set ? F3_CSRRS : F3_CSRRW, rd, OPC_SYSTEM), rd, old,
             1, ca, set ? (old | regs[rs1]) : regs[rs1]);
    endtask

    task automatic rand_op(input int regs_used);
        int rd;
        int rs1;
        int rs2;
        rd  = 1 + int'(rand_bits(2)) % regs_used;
        rs1 = 1 + int'(rand_bits(2)) % regs_used;
        rs2 = 1 + int'(rand_bits(2)) % regs_used;
        if (rand_bits(1) == 0)
            alu_r(r_ops[int'(rand_bits(4)) % 10], rd, rs1, rs2);
        else
            alu_i(i_ops[int'(rand_bits(4)) % 9], rd, rs1, 12'(rand_bits(12)));
    endtask

    // ************************************************************************
    // Monitor.
    // ************************************************************************
    always @(negedge clk) begin
        if (rst_n) begin
            if (interlock && (rf_we || csr_we)) begin
                $display("%s: write enable high during interlock", test_name);
                test_err++;
            end
            if (rf_we) begin
                if (gap_check && last_rf >= 0 && cyc - last_rf != 1) begin
                    $display("%s: retire pulse came %0d cycles after the previous one",
                             test_name, cyc - last_rf);
                    test_err++;
                end
                last_rf = cyc;
                if (rf_addr_q.size() == 0) begin
                    $display("%s: register write to x%0d with none expected",
                             test_name, rf_waddr);
                    test_err++;
                end else if (rf_addr_q[0] != int'(rf_waddr) || rf_data_q[0] != rf_wdata) begin
                    $display("ERR %s rf: expected x%0d=%h actual x%0d=%h", test_name,
                             rf_addr_q[0], rf_data_q[0], rf_waddr, rf_wdata);
                    test_err++;
                end
                if (rf_addr_q.size() != 0) begin
                    void'(rf_addr_q.pop_front());
                    void'(rf_data_q.pop_front());
                end
            end
            if (csr_we) begin
                if (csr_addr_q.size() == 0) begin
                    $display("%s: CSR write with none expected", test_name);
                    test_err++;
                end else begin
                    if (csr_addr_q[0] != int'(csr_waddr) || csr_data_q[0] != csr_wdata) begin
                        $display("ERR %s csr: expected %h=%h actual %h=%h", test_name,
                                 csr_addr_q[0], csr_data_q[0], csr_waddr, csr_wdata);
                        test_err++;
                    end
                    void'(csr_addr_q.pop_front());
                    void'(csr_data_q.pop_front());
                end
            end
        end
    end

    task automatic start_test(input string name);
        test_name = name;
        test_err  = 0;
    endtask

    task automatic finish_test();
        int n;
        n = 0;
        while ((rf_addr_q.size() != 0 || csr_addr_q.size() != 0) && n < 100) begin
            idle(1);
            n++;
        end
        idle(4); // Catch stray writes.
        if (rf_addr_q.size() != 0 || csr_addr_q.size() != 0) begin
            $display("%s: %0d expected writes never retired", test_name,
                     rf_addr_q.size() + csr_addr_q.size());
            test_err++;
            rf_addr_q.delete();
            rf_data_q.delete();
            csr_addr_q.delete();
            csr_data_q.delete();
        end
        $display("test %-10s %s (%0d errors)", test_name, test_err == 0 ? "ok" : "FAILED",
                 test_err);
        err_total += test_err;
        tests_run++;
    endtask

    // ************************************************************************
    // Tests.
    // ************************************************************************
    task automatic test_alu();
        start_test("alu");
        foreach (r_ops[k]) begin
            load_reg(1, rand_bits(32));
            load_reg(2, rand_bits(32));
            alu_r(r_ops[k], 3 + k, 1, 2);
        end
        foreach (i_ops[k]) begin
            load_reg(1, rand_bits(32));
            alu_i(i_ops[k], 14 + k, 1, 12'(rand_bits(12)));
        end
        alu_r(0, 0, 1, 2); // x0 target, no retire.
        alu_i(6, 0, 1, 12'h5a5);
        finish_test();
    endtask

    task automatic test_chain();
        start_test("chain");
        last_rf   = -1;
        gap_check = 1'b1;
        for (int r = 1; r <= 4; r++)
            load_reg(r, rand_bits(32));
        repeat (16)
            rand_op(4);
        finish_test();
        gap_check = 1'b0;
    endtask

    task automatic test_upper();
        logic [19:0] imm;
        start_test("upper");
        imm = 20'(rand_bits(20));
        send(enc_u(imm, 5, OPC_LUI), 5, {imm, 12'b0}, 0, '0, '0);
        imm = 20'(rand_bits(20));
        send(enc_u(imm, 6, OPC_AUIPC), 6, pc_q + {imm, 12'b0}, 0, '0, '0);
        send(enc_u(20'h00800, 7, OPC_JAL), 7, pc_q + 4, 0, '0, '0);
        send(enc_i(12'(rand_bits(12)), 5, 3'b000, 8, OPC_JALR), 8, pc_q + 4, 0, '0, '0);
        alu_r(0, 9, 7, 8); // Uses both links at once.
        finish_test();
    endtask

    task automatic test_csr();
        start_test("csr");
        load_reg(1, rand_bits(32));
        load_reg(2, rand_bits(32));
        csr_op(0, 3, 1, CSR_BASE);
        csr_op(1, 4, 2, CSR_BASE);
        csr_op(1, 5, 0, CSR_BASE);
        alu_r(4, 6, 5, 3);
        csr_op(0, 7, 2, csr_addr_t'(CSR_BASE + CSR_COUNT - 1));
        csr_op(1, 8, 1, csr_addr_t'(CSR_BASE + CSR_COUNT - 1));
        csr_op(0, 9, 1, 12'h7c0); // Outside the bank.
        csr_op(1, 10, 2, 12'h7c0);
        finish_test();
    endtask

    task automatic test_stall();
        start_test("stall");
        stall_mode = 1'b1;
        load_reg(1, rand_bits(32));
        repeat (30) begin
            if (rand_bits(2) == 0)
                idle(1 + int'(rand_bits(1)));
            if (rand_bits(3) == 0)
                csr_op(rand_bits(1) == 1, 1 + int'(rand_bits(2)), 1 + int'(rand_bits(2)),
                       csr_addr_t'(CSR_BASE + rand_bits(2)));
            else
                rand_op(4);
        end
        stall_mode = 1'b0;
        stall_left = 0;
        finish_test();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish in time");
        $display("Regression failed");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b1;
        interlock   = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        lfsr_q      = 32'd89859;
        pc_q        = 32'h0000_1000;
        err_total   = 0;
        tests_run   = 0;
        stall_mode  = 1'b0;
        stall_left  = 0;
        gap_check   = 1'b0;
        last_rf     = -1;
        test_name   = "reset";
        foreach (regs[k])
            regs[k] = '0;
        foreach (csrs[k])
            csrs[k] = '0;
        #1;
        rst_n = 1'b0; // Falling edge starts the asynchronous reset.
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_alu();
        test_chain();
        test_upper();
        test_csr();
        test_stall();
        $display("%0d tests, %0d errors", tests_run, err_total);
        if (err_total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
